/* verilog/ltssm_cfg_pkg.sv */
// shared widths, codes, timeouts and types for the Configuration substate logic
// imported by every RTL module of the block
`default_nettype none

package ltssm_cfg_pkg;

  // ------------------------------
  // lane and stream geometry
  // ------------------------------
  localparam int NUM_LANES    = 4;
  localparam int OCTET_W      = 8;
  localparam int WORD_W       = 32;
  localparam int KEEP_W       = 4;
  localparam int USER_W       = 8;
  localparam int WORDS_PER_OS = 4;
  localparam int WIDX_W       = $clog2(WORDS_PER_OS);

  // K23.7 in the link and lane fields
  localparam logic [OCTET_W-1:0] PAD_SYM = 8'hF7;

  // user codes seen by the transmitter
  localparam logic [USER_W-1:0] USER_LW_START = 8'h01;
  localparam logic [USER_W-1:0] USER_CFG      = 8'h03;

  // ------------------------------
  // receive thresholds
  // ------------------------------
  localparam int TS_CNT_W    = 4;
  localparam int TS1_NEEDED  = 2;
  localparam int TS2_NEEDED  = 8;
  localparam int IDLE_NEEDED = 8;
  localparam int IDLE_TX_MIN = 16;
  localparam int IDLE_TX_W   = $clog2(IDLE_TX_MIN + 1);

  // timeouts in clock cycles, scaled down for simulation
  localparam int TIMEOUT_LONG  = 600;
  localparam int TIMEOUT_SHORT = 200;
  localparam int TIMER_W       = 12;

  typedef enum logic [2:0] {
    IDLE,
    LW_START,
    LW_ACCEPT,
    LN_WAIT,
    LN_ACCEPT,
    COMPLETE,
    CFG_IDLE,
    WAIT_EN_LOW
  } cfg_state_e;

  // kind codes double as the symbol repeated through the block
  typedef enum logic [7:0] {
    TS1     = 8'h1E,
    TS2     = 8'h2D,
    SDS     = 8'hE1,
    IDLE_OS = 8'h00
  } os_kind_e;

  // word 0 carries link and lane fields, the rest repeat the kind code
  function automatic logic [WORD_W-1:0] os_word(input os_kind_e kind,
                                                input logic [OCTET_W-1:0] link,
                                                input logic [WIDX_W-1:0] idx);
    logic [OCTET_W-1:0] code;
    code = kind;
    if (idx == '0) begin
      os_word = {code, link, PAD_SYM, code};
    end else begin
      os_word = {4{code}};
    end
  endfunction

endpackage

`default_nettype wire

/* verilog/lane_os_counter.sv */
// per-lane qualification of received ordered sets in the current substate
// one instance per lane, lane_ok_o tells the controller the lane has met its threshold
`timescale 1ns/1ps
`default_nettype none

module lane_os_counter
  import ltssm_cfg_pkg::*;
(
  input  wire logic               clk_i,
  input  wire logic               rst_i,
  input  wire cfg_state_e         state_i,
  input  wire logic               ts1_valid_i,
  input  wire logic               ts2_valid_i,
  input  wire logic               idle_valid_i,
  input  wire logic [OCTET_W-1:0] link_num_i,
  input  wire logic [OCTET_W-1:0] lane_num_i,
  input  wire logic [OCTET_W-1:0] lane_num_tx_i,
  input  wire logic [OCTET_W-1:0] link_sel_i,
  input  wire logic               lane_active_i,
  output logic                    lane_ok_o,
  output logic [OCTET_W-1:0]      link_seen_o
);

  logic [TS_CNT_W-1:0] cnt_q;
  logic [TS_CNT_W-1:0] need;
  cfg_state_e          state_q;
  logic                os_valid;
  logic                os_match;
  logic                link_pad;
  logic                lane_pad;
  logic                link_is_sel;

  // zero means no counting in that substate
  function automatic logic [TS_CNT_W-1:0] threshold(input cfg_state_e s);
    case (s)
      LW_START, LW_ACCEPT, LN_WAIT, LN_ACCEPT: threshold = TS_CNT_W'(TS1_NEEDED);
      COMPLETE: threshold = TS_CNT_W'(TS2_NEEDED);
      CFG_IDLE: threshold = TS_CNT_W'(IDLE_NEEDED);
      default: threshold = '0;
    endcase
  endfunction

  assign link_pad    = (link_num_i == PAD_SYM);
  assign lane_pad    = (lane_num_i == PAD_SYM);
  assign link_is_sel = (link_num_i == link_sel_i);
  assign need        = threshold(state_i);

  // which received set counts, and whether it qualifies
  always_comb begin
    os_valid = 1'b0;
    os_match = 1'b0;
    case (state_i)
      LW_START: begin
        os_valid = ts1_valid_i;
        os_match = !link_pad && lane_pad;
      end
      LW_ACCEPT: begin
        os_valid = ts1_valid_i;
        os_match = link_is_sel;
      end
      LN_WAIT: begin
        os_valid = ts1_valid_i;
        os_match = !link_pad && !lane_pad;
      end
      LN_ACCEPT: begin
        os_valid = ts1_valid_i;
        os_match = link_is_sel && !lane_pad;
      end
      COMPLETE: begin
        os_valid = ts2_valid_i;
        os_match = link_is_sel && (lane_num_i == lane_num_tx_i);
      end
      CFG_IDLE: begin
        // any training set breaks the idle run
        os_valid = idle_valid_i || ts1_valid_i || ts2_valid_i;
        os_match = idle_valid_i && !ts1_valid_i && !ts2_valid_i;
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      cnt_q   <= '0;
      state_q <= IDLE;
    end else begin
      state_q <= state_i;
      if (state_i != state_q) begin
        cnt_q <= '0;
      end else if (os_valid) begin
        if (!os_match) begin
          cnt_q <= '0;
        end else if (cnt_q != need) begin
          cnt_q <= cnt_q + 1'b1;
        end
      end
    end
  end

  // latest link number heard on this lane
  always_ff @(posedge clk_i) begin
    if (ts1_valid_i || ts2_valid_i) begin
      link_seen_o <= link_num_i;
    end
  end

  // inactive lanes do not hold up Configuration.Complete
  assign lane_ok_o = (state_i == COMPLETE && !lane_active_i) ||
                     ((state_i == state_q) && (need != '0) && (cnt_q == need));

  // count was last updated under state_q, so it must respect that threshold
  a_cnt_bound: assert property (@(posedge clk_i) disable iff (rst_i)
    cnt_q <= threshold(state_q))
    else $error("lane count above its threshold");

endmodule

`default_nettype wire

/* verilog/cfg_substate_fsm.sv */
// Configuration substate controller of the downstream port
// decides at block boundaries, owns the timeout timer and the selected link number
`timescale 1ns/1ps
`default_nettype none

module cfg_substate_fsm
  import ltssm_cfg_pkg::*;
(
  input  wire logic                         clk_i,
  input  wire logic                         rst_i,
  input  wire logic                         en_i,
  input  wire logic [NUM_LANES-1:0]         lane_ok_i,
  input  wire logic [NUM_LANES*OCTET_W-1:0] link_seen_i,
  input  wire logic                         block_done_i,
  output cfg_state_e                        state_o,
  output logic                              tx_en_o,
  output os_kind_e                          os_kind_o,
  output logic [OCTET_W-1:0]                link_sel_o,
  output logic                              success_o,
  output logic                              error_o
);

  cfg_state_e           state_q, state_d;
  os_kind_e             kind_q, kind_d;
  logic [OCTET_W-1:0]   link_q, link_d;
  logic [TIMER_W-1:0]   timer_q, timer_d;
  logic [TIMER_W-1:0]   limit;
  logic [IDLE_TX_W-1:0] idle_cnt_q, idle_cnt_d;
  logic                 success_q, success_d;
  logic                 error_q, error_d;
  logic                 any_ok;
  logic                 all_ok;
  logic                 timed_out;
  logic [OCTET_W-1:0]   lowest_link;

  assign any_ok    = |lane_ok_i;
  assign all_ok    = &lane_ok_i;
  assign limit     = (state_q == LW_START) ? TIMER_W'(TIMEOUT_LONG) : TIMER_W'(TIMEOUT_SHORT);
  assign timed_out = (timer_q >= limit);

  // link number of the lowest ok lane
  always_comb begin
    lowest_link = link_q;
    for (int i = NUM_LANES - 1; i >= 0; i--) begin
      if (lane_ok_i[i]) begin
        lowest_link = link_seen_i[i*OCTET_W +: OCTET_W];
      end
    end
  end

  // ------------------------------
  // next-state logic
  // ------------------------------
  always_comb begin
    state_d    = state_q;
    kind_d     = kind_q;
    link_d     = link_q;
    idle_cnt_d = idle_cnt_q;
    success_d  = success_q;
    error_d    = error_q;
    timer_d    = timed_out ? limit : timer_q + 1'b1;

    case (state_q)
      IDLE: begin
        if (en_i) begin
          state_d    = LW_START;
          kind_d     = TS1;
          link_d     = PAD_SYM;
          idle_cnt_d = '0;
        end
      end
      LW_START: begin
        if (block_done_i) begin
          if (any_ok) begin
            state_d = LW_ACCEPT;
            link_d  = lowest_link;
          end else if (timed_out) begin
            state_d = WAIT_EN_LOW;
            error_d = 1'b1;
          end
        end
      end
      LW_ACCEPT, LN_WAIT: begin
        if (block_done_i) begin
          if (any_ok) begin
            state_d = (state_q == LW_ACCEPT) ? LN_WAIT : LN_ACCEPT;
          end else if (timed_out) begin
            state_d = WAIT_EN_LOW;
            error_d = 1'b1;
          end
        end
      end
      LN_ACCEPT: begin
        if (block_done_i) begin
          if (any_ok) begin
            state_d = COMPLETE;
            kind_d  = TS2;
          end else if (timed_out) begin
            state_d = WAIT_EN_LOW;
            error_d = 1'b1;
          end
        end
      end
      COMPLETE: begin
        if (block_done_i) begin
          if (all_ok) begin
            // one SDS block first, idles follow
            state_d = CFG_IDLE;
            kind_d  = SDS;
          end else if (timed_out) begin
            state_d = WAIT_EN_LOW;
            error_d = 1'b1;
          end
        end
      end
      CFG_IDLE: begin
        if (block_done_i) begin
          kind_d = IDLE_OS;
          // idle reception shows up as lane_ok in this substate
          if (any_ok && idle_cnt_q >= IDLE_TX_W'(IDLE_TX_MIN)) begin
            state_d   = WAIT_EN_LOW;
            success_d = 1'b1;
          end else if (timed_out) begin
            state_d = WAIT_EN_LOW;
            error_d = 1'b1;
          end else if (any_ok) begin
            idle_cnt_d = idle_cnt_q + 1'b1;
          end
        end
      end
      WAIT_EN_LOW: begin
        if (!en_i) begin
          state_d   = IDLE;
          success_d = 1'b0;
          error_d   = 1'b0;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase

    // fresh timer on every substate entry
    if (state_d != state_q) begin
      timer_d = '0;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q    <= IDLE;
      kind_q     <= TS1;
      link_q     <= PAD_SYM;
      timer_q    <= '0;
      idle_cnt_q <= '0;
      success_q  <= 1'b0;
      error_q    <= 1'b0;
    end else begin
      state_q    <= state_d;
      kind_q     <= kind_d;
      link_q     <= link_d;
      timer_q    <= timer_d;
      idle_cnt_q <= idle_cnt_d;
      success_q  <= success_d;
      error_q    <= error_d;
    end
  end

  assign state_o    = state_q;
  assign os_kind_o  = kind_q;
  assign link_sel_o = link_q;
  assign success_o  = success_q;
  assign error_o    = error_q;
  assign tx_en_o    = (state_q != IDLE) && (state_q != WAIT_EN_LOW);

  // a verdict only exists while parked, and there is only one
  a_verdict: assert property (@(posedge clk_i) disable iff (rst_i)
    (success_o || error_o) |-> (state_q == WAIT_EN_LOW) && !(success_o && error_o))
    else $error("success and error overlap or verdict outside WAIT_EN_LOW");

endmodule

`default_nettype wire

/* verilog/os_block_serializer.sv */
// turns the requested ordered-set kind into four-word AXI-stream blocks
// valid drops for one cycle between blocks, back-pressure only stretches a block
`timescale 1ns/1ps
`default_nettype none

module os_block_serializer
  import ltssm_cfg_pkg::*;
(
  input  wire logic               clk_i,
  input  wire logic               rst_i,
  input  wire logic               tx_en_i,
  input  wire os_kind_e           os_kind_i,
  input  wire logic [OCTET_W-1:0] link_sel_i,
  input  wire cfg_state_e         state_i,
  input  wire logic               m_axis_tready_i,
  output logic [WORD_W-1:0]       m_axis_tdata_o,
  output logic [KEEP_W-1:0]       m_axis_tkeep_o,
  output logic                    m_axis_tvalid_o,
  output logic                    m_axis_tlast_o,
  output logic [USER_W-1:0]       m_axis_tuser_o,
  output logic                    block_done_o
);

  localparam logic [WIDX_W-1:0] LAST_IDX = WIDX_W'(WORDS_PER_OS - 1);

  logic              valid_q;
  logic [WIDX_W-1:0] widx_q;
  logic              start;
  logic              advance;

  assign start   = !valid_q && tx_en_i;
  assign advance = valid_q && m_axis_tready_i;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
      widx_q  <= '0;
    end else if (start) begin
      valid_q <= 1'b1;
      widx_q  <= '0;
    end else if (advance) begin
      if (widx_q == LAST_IDX) begin
        valid_q <= 1'b0;
        widx_q  <= '0;
      end else begin
        widx_q <= widx_q + 1'b1;
      end
    end
  end

  // payload, user code fixed for the whole block
  always_ff @(posedge clk_i) begin
    if (start) begin
      m_axis_tdata_o <= os_word(os_kind_i, link_sel_i, '0);
      m_axis_tlast_o <= 1'b0;
      m_axis_tuser_o <= (state_i == LW_START) ? USER_LW_START : USER_CFG;
    end else if (advance && widx_q != LAST_IDX) begin
      m_axis_tdata_o <= os_word(os_kind_i, link_sel_i, widx_q + 1'b1);
      m_axis_tlast_o <= (widx_q + 1'b1 == LAST_IDX);
    end
  end

  assign m_axis_tvalid_o = valid_q;
  assign m_axis_tkeep_o  = '1;
  assign block_done_o    = advance && m_axis_tlast_o;

  a_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    m_axis_tvalid_o && !m_axis_tready_i |=>
      m_axis_tvalid_o && $stable({m_axis_tdata_o, m_axis_tlast_o, m_axis_tuser_o}))
    else $error("stream payload changed under back-pressure");

endmodule

`default_nettype wire

/* verilog/ltssm_cfg_top.sv */
// Configuration substates of the LTSSM, downstream port
// lane counters feed the substate controller, which drives the ordered-set serializer
`timescale 1ns/1ps
`default_nettype none

module ltssm_cfg_top
  import ltssm_cfg_pkg::*;
(
  input  wire logic                         clk_i,
  input  wire logic                         rst_i,
  input  wire logic                         en_i,
  input  wire logic [NUM_LANES-1:0]         ts1_valid_i,
  input  wire logic [NUM_LANES-1:0]         ts2_valid_i,
  input  wire logic [NUM_LANES-1:0]         idle_valid_i,
  input  wire logic [NUM_LANES-1:0]         lane_active_i,
  input  wire logic [NUM_LANES*OCTET_W-1:0] link_num_i,
  input  wire logic [NUM_LANES*OCTET_W-1:0] lane_num_i,
  input  wire logic [NUM_LANES*OCTET_W-1:0] lane_num_tx_i,
  input  wire logic                         m_axis_tready_i,
  output logic                              success_o,
  output logic                              error_o,
  output logic [WORD_W-1:0]                 m_axis_tdata_o,
  output logic [KEEP_W-1:0]                 m_axis_tkeep_o,
  output logic                              m_axis_tvalid_o,
  output logic                              m_axis_tlast_o,
  output logic [USER_W-1:0]                 m_axis_tuser_o
);

  logic [NUM_LANES-1:0]         lane_ok;
  logic [NUM_LANES*OCTET_W-1:0] link_seen;
  cfg_state_e                   cfg_state;
  logic                         tx_en;
  os_kind_e                     os_kind;
  logic [OCTET_W-1:0]           link_sel;
  logic                         block_done;

  // ------------------------------
  // receive side, one per lane
  // ------------------------------
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    lane_os_counter u_lane (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .state_i      (cfg_state),
      .ts1_valid_i  (ts1_valid_i[i]),
      .ts2_valid_i  (ts2_valid_i[i]),
      .idle_valid_i (idle_valid_i[i]),
      .link_num_i   (link_num_i[i*OCTET_W +: OCTET_W]),
      .lane_num_i   (lane_num_i[i*OCTET_W +: OCTET_W]),
      .lane_num_tx_i(lane_num_tx_i[i*OCTET_W +: OCTET_W]),
      .link_sel_i   (link_sel),
      .lane_active_i(lane_active_i[i]),
      .lane_ok_o    (lane_ok[i]),
      .link_seen_o  (link_seen[i*OCTET_W +: OCTET_W])
    );
  end

  cfg_substate_fsm u_fsm (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .en_i        (en_i),
    .lane_ok_i   (lane_ok),
    .link_seen_i (link_seen),
    .block_done_i(block_done),
    .state_o     (cfg_state),
    .tx_en_o     (tx_en),
    .os_kind_o   (os_kind),
    .link_sel_o  (link_sel),
    .success_o   (success_o),
    .error_o     (error_o)
  );

  // transmit side
  os_block_serializer u_ser (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .tx_en_i        (tx_en),
    .os_kind_i      (os_kind),
    .link_sel_i     (link_sel),
    .state_i        (cfg_state),
    .m_axis_tready_i(m_axis_tready_i),
    .m_axis_tdata_o (m_axis_tdata_o),
    .m_axis_tkeep_o (m_axis_tkeep_o),
    .m_axis_tvalid_o(m_axis_tvalid_o),
    .m_axis_tlast_o (m_axis_tlast_o),
    .m_axis_tuser_o (m_axis_tuser_o),
    .block_done_o   (block_done)
  );

endmodule

`default_nettype wire

/* verif/tb_clk_gen.sv */
// clock and power-on reset for the Configuration testbench
// 40 ns clock, reset released 2 ns after the fifth rising edge
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_o
);

  localparam int HALF_PERIOD_NS = 20;
  localparam int RESET_CYCLES   = 5;

  initial begin
    clk_o = 1'b0;
    forever begin
      #HALF_PERIOD_NS;
      clk_o = ~clk_o;
    end
  end

  initial begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #2;
    rst_o = 1'b0;
  end

endmodule

`default_nettype wire

/* verif/tb_ltssm_cfg.sv */
// testbench for the Configuration substates with a lane partner model and stream checks
// runs a full configuration, a Linkwidth.Start timeout, then a second configuration
`timescale 1ns/1ps
`default_nettype none

module tb_ltssm_cfg
  import ltssm_cfg_pkg::*;
();

  localparam int BLOCK_CYCLES = WORDS_PER_OS + 1;
  // one pass through every substate timeout, with some block slack
  localparam int RUN_LIMIT    = TIMEOUT_LONG + 5 * TIMEOUT_SHORT + 8 * BLOCK_CYCLES;
  localparam int WATCHDOG_CYC = 3 * RUN_LIMIT;
  localparam logic [15:0] LFSR_SEED = 16'd6923;

  logic                         clk;
  logic                         rst;
  logic                         en;
  logic [NUM_LANES-1:0]         ts1_valid;
  logic [NUM_LANES-1:0]         ts2_valid;
  logic [NUM_LANES-1:0]         idle_valid;
  logic [NUM_LANES-1:0]         lane_active;
  logic [NUM_LANES*OCTET_W-1:0] link_num;
  logic [NUM_LANES*OCTET_W-1:0] lane_num;
  logic [NUM_LANES*OCTET_W-1:0] lane_num_tx;
  logic                         tready;
  logic                         success;
  logic                         dut_error;
  logic [WORD_W-1:0]            tdata;
  logic [KEEP_W-1:0]            tkeep;
  logic                         tvalid;
  logic                         tlast;
  logic [USER_W-1:0]            tuser;

  // stimulus state, owned by the main process
  logic [15:0]        lfsr;
  logic               partner_on;
  logic               stall_en;
  int                 first_lane;
  logic [OCTET_W-1:0] lane_links [NUM_LANES];
  logic [OCTET_W-1:0] exp_link;
  logic [7:0]         phase_kind;
  logic [USER_W-1:0]  phase_user;
  int                 run_id = 0;
  int                 run_mism = 0;
  int                 run_other = 0;

  // stream monitor state
  int                 mon_run = 0;
  int                 mon_mism = 0;
  int                 mon_other = 0;
  int                 beat;
  int                 blocks;
  int                 kind_stage;
  int                 k_stage;
  int                 sds_blocks;
  int                 idle_blocks;
  logic               sel_seen;
  logic               sel_now;
  logic [7:0]         blk_kind;
  logic [USER_W-1:0]  blk_user;
  logic               prev_valid;
  logic               prev_ready;
  logic [WORD_W-1:0]  prev_data;
  logic               prev_last;
  logic [USER_W-1:0]  prev_user;

  tb_clk_gen u_clk (
    .clk_o(clk),
    .rst_o(rst)
  );

  ltssm_cfg_top dut_i (
    .clk_i          (clk),
    .rst_i          (rst),
    .en_i           (en),
    .ts1_valid_i    (ts1_valid),
    .ts2_valid_i    (ts2_valid),
    .idle_valid_i   (idle_valid),
    .lane_active_i  (lane_active),
    .link_num_i     (link_num),
    .lane_num_i     (lane_num),
    .lane_num_tx_i  (lane_num_tx),
    .m_axis_tready_i(tready),
    .success_o      (success),
    .error_o        (dut_error),
    .m_axis_tdata_o (tdata),
    .m_axis_tkeep_o (tkeep),
    .m_axis_tvalid_o(tvalid),
    .m_axis_tlast_o (tlast),
    .m_axis_tuser_o (tuser)
  );

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic void show_mismatch(input string name, input logic [31:0] got,
                                        input logic [31:0] exp);
    $display("Fail at %0t ns: %s expected %0h, got %0h", $time, name, exp, got);
  endfunction

  task automatic take_bits(input int n, output logic [7:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      bits = {bits[6:0], lfsr[15]};
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got == exp) else begin
      show_mismatch(name, got, exp);
      run_mism++;
    end
  endtask

  task automatic check_stream(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    assert (got == exp) else begin
      show_mismatch(name, got, exp);
      mon_mism++;
    end
  endtask

  // ------------------------------
  // per-cycle drive: tready and the lane partner
  // ------------------------------
  task automatic step_cycle();
    logic [7:0] r;
    @(posedge clk);
    #2;
    tready = 1'b1;
    if (stall_en) begin
      // about one cycle in four stalls
      take_bits(2, r);
      tready = (r[1:0] != 2'b11);
    end
    // every word repeats the kind in its top byte
    if (tvalid) begin
      phase_kind = tdata[31:24];
      phase_user = tuser;
    end
    ts1_valid  = '0;
    ts2_valid  = '0;
    idle_valid = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      link_num[i*OCTET_W +: OCTET_W] = exp_link;
      lane_num[i*OCTET_W +: OCTET_W] = 8'(i);
      if (partner_on) begin
        case (phase_kind)
          TS1: begin
            ts1_valid[i] = 1'b1;
            // Linkwidth.Start, lanes below first_lane offer no link
            if (phase_user == USER_LW_START) begin
              link_num[i*OCTET_W +: OCTET_W] = (i < first_lane) ? PAD_SYM : lane_links[i];
              lane_num[i*OCTET_W +: OCTET_W] = PAD_SYM;
            end
          end
          TS2: ts2_valid[i] = 1'b1;
          SDS, IDLE_OS: idle_valid[i] = 1'b1;
          default: ;
        endcase
      end
    end
  endtask

  task automatic wait_verdict(output int cycles);
    cycles = 0;
    while (!success && !dut_error && cycles < RUN_LIMIT) begin
      step_cycle();
      cycles++;
    end
    assert (cycles < RUN_LIMIT) else begin
      $display("no success or error within %0d cycles of enable", RUN_LIMIT);
      run_other++;
    end
  endtask

  task automatic run_full();
    logic [7:0] r;
    int         cycles;
    take_bits(2, r);
    first_lane = int'(r[1:0]);
    take_bits(5, r);
    // top bit clear keeps every link off PAD, lane index keeps them distinct
    for (int i = 0; i < NUM_LANES; i++) begin
      lane_links[i] = {1'b0, r[4:0], 2'(i)};
    end
    exp_link   = lane_links[first_lane];
    partner_on = 1'b1;
    stall_en   = 1'b1;
    phase_kind = 8'hFF;
    run_id++;
    en = 1'b1;
    wait_verdict(cycles);
    check_value("success_o", 32'(success), 32'd1);
    check_value("error_o", 32'(dut_error), 32'd0);
    check_value("SDS block count", 32'(sds_blocks), 32'd1);
    assert (idle_blocks >= IDLE_TX_MIN) else begin
      $display("only %0d idle blocks before success", idle_blocks);
      run_other++;
    end
  endtask

  task automatic run_timeout();
    int cycles;
    partner_on = 1'b0;
    stall_en   = 1'b0;
    run_id++;
    en = 1'b1;
    wait_verdict(cycles);
    check_value("error_o", 32'(dut_error), 32'd1);
    check_value("success_o", 32'(success), 32'd0);
    check_value("highest block kind stage", 32'(kind_stage), 32'd0);
    // enable and verdict registers add one cycle each
    assert (cycles >= TIMEOUT_LONG && cycles <= TIMEOUT_LONG + BLOCK_CYCLES + 2) else begin
      $display("error came %0d cycles after enable, outside the timeout window", cycles);
      run_other++;
    end
  endtask

  task automatic release_enable();
    en = 1'b0;
    step_cycle();
    step_cycle();
    check_value("success_o", 32'(success), 32'd0);
    check_value("error_o", 32'(dut_error), 32'd0);
    check_value("m_axis_tvalid_o", 32'(tvalid), 32'd0);
  endtask

  // ------------------------------
  // stream monitor
  // ------------------------------
  always @(posedge clk) begin
    if (rst || run_id != mon_run) begin
      mon_run     = run_id;
      beat        = 0;
      blocks      = 0;
      kind_stage  = 0;
      sds_blocks  = 0;
      idle_blocks = 0;
      sel_seen    = 1'b0;
      prev_valid  = 1'b0;
    end else begin
      // payload frozen while stalled
      if (prev_valid && !prev_ready) begin
        check_stream("m_axis_tvalid_o", 32'(tvalid), 32'd1);
        check_stream("m_axis_tdata_o", tdata, prev_data);
        check_stream("m_axis_tlast_o", 32'(tlast), 32'(prev_last));
        check_stream("m_axis_tuser_o", 32'(tuser), 32'(prev_user));
      end
      if (tvalid && tready) begin
        check_stream("m_axis_tkeep_o", 32'(tkeep), 32'hF);
        check_stream("m_axis_tlast_o", 32'(tlast), 32'(beat == WORDS_PER_OS - 1));
        if (beat == 0) begin
          blk_kind = tdata[31:24];
          case (blk_kind)
            TS1:     k_stage = 0;
            TS2:     k_stage = 1;
            SDS:     k_stage = 2;
            IDLE_OS: k_stage = 3;
            default: k_stage = 4;
          endcase
          // TS1 first, no kind skipped, SDS only once
          assert (k_stage < 4 && (blocks == 0 ? k_stage == 0 :
                  (k_stage == kind_stage || k_stage == kind_stage + 1) &&
                  !(k_stage == 2 && kind_stage == 2))) else begin
            $display("block kind %0h out of order after stage %0d", blk_kind, kind_stage);
            mon_other++;
          end
          // link field leaves PAD once Linkwidth.Start is done
          sel_now  = sel_seen || k_stage != 0 || tdata[23:16] != PAD_SYM;
          sel_seen = sel_now;
          blk_user = sel_now ? USER_CFG : USER_LW_START;
          check_stream("m_axis_tdata_o", tdata,
                       {blk_kind, (sel_now ? exp_link : PAD_SYM), PAD_SYM, blk_kind});
          kind_stage = k_stage;
          blocks++;
          if (k_stage == 2) begin
            sds_blocks++;
          end
          if (k_stage == 3) begin
            idle_blocks++;
          end
        end else begin
          check_stream("m_axis_tdata_o", tdata, {4{blk_kind}});
        end
        check_stream("m_axis_tuser_o", 32'(tuser), 32'(blk_user));
        beat = (beat == WORDS_PER_OS - 1) ? 0 : beat + 1;
      end
      prev_valid = tvalid;
      prev_ready = tready;
      prev_data  = tdata;
      prev_last  = tlast;
      prev_user  = tuser;
    end
  end

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    en          = 1'b0;
    tready      = 1'b0;
    ts1_valid   = '0;
    ts2_valid   = '0;
    idle_valid  = '0;
    lane_active = '1;
    link_num    = '0;
    lane_num    = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      lane_num_tx[i*OCTET_W +: OCTET_W] = 8'(i);
    end
    lfsr       = LFSR_SEED;
    partner_on = 1'b0;
    stall_en   = 1'b0;
    first_lane = 0;
    exp_link   = PAD_SYM;
    phase_kind = 8'hFF;
    phase_user = '0;
    @(negedge rst);
    @(posedge clk);
    #2;
    check_value("m_axis_tvalid_o", 32'(tvalid), 32'd0);
    check_value("success_o", 32'(success), 32'd0);
    check_value("error_o", 32'(dut_error), 32'd0);
    run_full();
    release_enable();
    run_timeout();
    release_enable();
    run_full();
    $display("checks failed: %0d value mismatches, %0d other failures",
             run_mism + mon_mism, run_other + mon_other);
    if (run_mism + mon_mism + run_other + mon_other == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (WATCHDOG_CYC) @(posedge clk);
    $display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYC);
    $display("checks failed: %0d value mismatches, %0d other failures",
             run_mism + mon_mism, run_other + mon_other + 1);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
verilog/ltssm_cfg_pkg.sv
verilog/lane_os_counter.sv
verilog/cfg_substate_fsm.sv
verilog/os_block_serializer.sv
verilog/ltssm_cfg_top.sv
verif/tb_clk_gen.sv
verif/tb_ltssm_cfg.sv

/* run_sim.sh */
#!/bin/sh
# build and run the Configuration testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_ltssm_cfg -f src.f -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1 ; cat sim.log \
  && grep -q "^RESULT: PASS$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
